// File: hw/sb_pkg.sv
`default_nettype none

package sb_pkg;

	typedef logic [3:0] io_addr_t;          // offset inside the 220h window
	typedef logic [7:0] byte_t;
	typedef logic [4:0] vol_t;              // 0 is mute
	typedef logic signed [15:0] sample_t;
	typedef logic [27:0] rate_t;            // system clock in Hz

	// host port offsets
	localparam io_addr_t PORT_MIX_INDEX  = 4'h4;
	localparam io_addr_t PORT_MIX_DATA   = 4'h5;
	localparam io_addr_t PORT_DSP_RESET  = 4'h6;
	localparam io_addr_t PORT_DSP_READ   = 4'hA;
	localparam io_addr_t PORT_DSP_WRITE  = 4'hC;
	localparam io_addr_t PORT_DSP_STATUS = 4'hE;

	// SB Pro combined registers
	localparam byte_t MIX_RESET    = 8'h00;
	localparam byte_t MIX_VOICE    = 8'h04;
	localparam byte_t MIX_STEREO   = 8'h0E;
	localparam byte_t MIX_MASTER   = 8'h22;
	localparam byte_t MIX_MIDI     = 8'h26;
	localparam byte_t MIX_CD       = 8'h28;
	localparam byte_t MIX_LINE     = 8'h2E;

	// SB16 per-channel registers
	localparam byte_t MIX_MASTER_L = 8'h30;
	localparam byte_t MIX_MASTER_R = 8'h31;
	localparam byte_t MIX_VOICE_L  = 8'h32;
	localparam byte_t MIX_VOICE_R  = 8'h33;
	localparam byte_t MIX_MIDI_L   = 8'h34;
	localparam byte_t MIX_MIDI_R   = 8'h35;
	localparam byte_t MIX_CD_L     = 8'h36;
	localparam byte_t MIX_CD_R     = 8'h37;
	localparam byte_t MIX_LINE_L   = 8'h38;
	localparam byte_t MIX_LINE_R   = 8'h39;
	localparam byte_t MIX_SPK      = 8'h3B;
	localparam byte_t MIX_OUT_EN   = 8'h3C;
	localparam byte_t MIX_REC_L    = 8'h3D;
	localparam byte_t MIX_REC_R    = 8'h3E;

	localparam byte_t MIX_IRQ_SEL  = 8'h80;
	localparam byte_t MIX_DMA_SEL  = 8'h81;
	localparam byte_t MIX_IRQ_STAT = 8'h82;

	// DSP commands and replies
	localparam byte_t DSP_CMD_DAC     = 8'h10;
	localparam byte_t DSP_CMD_VERSION = 8'hE1;
	localparam byte_t DSP_CMD_IRQ8    = 8'hF2;
	localparam byte_t DSP_RESET_ACK   = 8'hAA;
	localparam byte_t DSP_VER_MAJOR   = 8'h04;
	localparam byte_t DSP_VER_MINOR   = 8'h05;

	localparam int unsigned DSP_RESET_US = 20;  // delay before the AAh reply

	typedef enum logic [2:0] {IDLE, RESET_HOLD, RESET_WAIT, CMD, DAC_ARG} dsp_state_t;

endpackage

`default_nettype wire

// File: hw/sb_ce_gen.sv
`default_nettype none

module sb_ce_gen #(
	parameter int unsigned TICK_HZ = 1000000
) (
	input  logic          clk,
	input  logic          rst_n,
	input  sb_pkg::rate_t clock_rate,
	output logic          ce
);
	import sb_pkg::*;

	localparam logic [28:0] TICK = 29'(TICK_HZ);

	rate_t       clk_rate;
	rate_t       acc;
	logic [28:0] sum;   // one spare bit so acc + TICK cannot wrap

	always_ff @(posedge clk)
		clk_rate <= clock_rate;

	assign sum = {1'b0, acc} + TICK;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc <= '0;
			ce  <= 1'b0;
		end else if (sum >= {1'b0, clk_rate}) begin
			acc <= rate_t'(sum - {1'b0, clk_rate});
			ce  <= 1'b1;
		end else begin
			acc <= sum[27:0];
			ce  <= 1'b0;
		end
	end

	// after a tick the remainder is below TICK, so the next one needs at least two cycles
	a_ce_spaced: assert property (@(posedge clk) disable iff (!rst_n)
		(clk_rate > 2 * TICK_HZ) && ce |=> !ce);

endmodule

`default_nettype wire

// File: hw/sb_mixer_regs.sv
`default_nettype none

module sb_mixer_regs (
	input  logic             clk,
	input  logic             rst_n,
	input  sb_pkg::io_addr_t io_address,
	input  logic             io_write,
	input  sb_pkg::byte_t    io_writedata,
	input  logic             irq8,
	input  logic             irq16,
	output sb_pkg::byte_t    mixer_val,
	output sb_pkg::vol_t     vol_master_l,
	output sb_pkg::vol_t     vol_master_r,
	output sb_pkg::vol_t     vol_voice_l,
	output sb_pkg::vol_t     vol_voice_r,
	output sb_pkg::vol_t     vol_midi_l,
	output sb_pkg::vol_t     vol_midi_r,
	output sb_pkg::vol_t     vol_cd_l,
	output sb_pkg::vol_t     vol_cd_r,
	output sb_pkg::vol_t     vol_line_l,
	output sb_pkg::vol_t     vol_line_r,
	output logic [1:0]       vol_spk,
	output logic [4:0]       vol_en,
	output logic             irq_7_en,
	output logic             irq_10_en,
	output logic             dma_16_en,
	output logic             sbp_stereo
);
	import sb_pkg::*;

	byte_t      mix_index;
	logic       sbp;            // SB Pro compatible map
	logic [6:0] rec_l;
	logic [6:0] rec_r;
	logic       irq_5_en;
	logic       index_wr;
	logic       data_wr;
	logic       mix_reset;
	logic [9:0] comb_vol;       // {left, right} from a combined register
	byte_t      vol_mask;
	byte_t      chan_rd;

	assign index_wr  = io_write && io_address == PORT_MIX_INDEX;
	assign data_wr   = io_write && io_address == PORT_MIX_DATA;
	assign mix_reset = data_wr && mix_index == MIX_RESET;
	assign irq_5_en  = !irq_7_en && !irq_10_en;
	assign vol_mask  = sbp ? 8'hEE : 8'hFF;

	// SBP repeats the nibble msb, SB16 repeats the top two bits of the 3-bit field
	assign comb_vol = sbp ?
		{io_writedata[7:4], io_writedata[7], io_writedata[3:0], io_writedata[3]} :
		{io_writedata[7:5], io_writedata[7:6], io_writedata[3:1], io_writedata[3:2]};

	always_ff @(posedge clk) begin
		if (!rst_n)
			mix_index <= '0;
		else if (index_wr)
			mix_index <= io_writedata;
	end

	// irq/dma select, also the SBP mode switch
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sbp       <= 1'b0;
			irq_7_en  <= 1'b0;
			irq_10_en <= 1'b0;
			dma_16_en <= 1'b1;
		end else if (data_wr && mix_index == MIX_IRQ_SEL) begin
			if (io_writedata == 8'hAD) begin
				sbp <= 1'b1;
			end else if (io_writedata == 8'hAE) begin
				sbp <= 1'b0;
			end else begin
				irq_7_en  <= io_writedata[3:2] == 2'b01;
				irq_10_en <= io_writedata[3:2] == 2'b10;
			end
		end else if (data_wr && mix_index == MIX_DMA_SEL) begin
			dma_16_en <= io_writedata[5];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n || mix_reset) begin
			{vol_master_l, vol_master_r} <= '1;
			{vol_voice_l, vol_voice_r}   <= '1;
			{vol_midi_l, vol_midi_r}     <= '1;
			{vol_cd_l, vol_cd_r}         <= '1;
			{vol_line_l, vol_line_r}     <= '1;
			vol_spk    <= 2'd3;
			vol_en     <= 5'b11111;
			sbp_stereo <= 1'b0;
			rec_l      <= 7'b0010101;
			rec_r      <= 7'b0001011;
		end else if (data_wr) begin
			case (mix_index)
				MIX_VOICE:  {vol_voice_l, vol_voice_r} <= comb_vol;
				MIX_STEREO: sbp_stereo <= io_writedata[1] & sbp;  // SB Pro only
				MIX_MASTER: {vol_master_l, vol_master_r} <= comb_vol;
				MIX_MIDI:   {vol_midi_l, vol_midi_r} <= comb_vol;
				MIX_CD:     {vol_cd_l, vol_cd_r} <= comb_vol;
				MIX_LINE:   {vol_line_l, vol_line_r} <= comb_vol;
				default: ;
			endcase
			if (!sbp) begin
				case (mix_index)
					MIX_MASTER_L: vol_master_l <= io_writedata[7:3];
					MIX_MASTER_R: vol_master_r <= io_writedata[7:3];
					MIX_VOICE_L:  vol_voice_l  <= io_writedata[7:3];
					MIX_VOICE_R:  vol_voice_r  <= io_writedata[7:3];
					MIX_MIDI_L:   vol_midi_l   <= io_writedata[7:3];
					MIX_MIDI_R:   vol_midi_r   <= io_writedata[7:3];
					MIX_CD_L:     vol_cd_l     <= io_writedata[7:3];
					MIX_CD_R:     vol_cd_r     <= io_writedata[7:3];
					MIX_LINE_L:   vol_line_l   <= io_writedata[7:3];
					MIX_LINE_R:   vol_line_r   <= io_writedata[7:3];
					MIX_SPK:      vol_spk      <= io_writedata[7:6];
					MIX_OUT_EN:   vol_en       <= io_writedata[4:0];
					MIX_REC_L:    rec_l        <= io_writedata[6:0];
					MIX_REC_R:    rec_r        <= io_writedata[6:0];
					default: ;
				endcase
			end
		end
	end

	// SB16 per-channel view
	always_comb begin
		case (mix_index)
			MIX_MASTER_L: chan_rd = {vol_master_l, 3'd0};
			MIX_MASTER_R: chan_rd = {vol_master_r, 3'd0};
			MIX_VOICE_L:  chan_rd = {vol_voice_l, 3'd0};
			MIX_VOICE_R:  chan_rd = {vol_voice_r, 3'd0};
			MIX_MIDI_L:   chan_rd = {vol_midi_l, 3'd0};
			MIX_MIDI_R:   chan_rd = {vol_midi_r, 3'd0};
			MIX_CD_L:     chan_rd = {vol_cd_l, 3'd0};
			MIX_CD_R:     chan_rd = {vol_cd_r, 3'd0};
			MIX_LINE_L:   chan_rd = {vol_line_l, 3'd0};
			MIX_LINE_R:   chan_rd = {vol_line_r, 3'd0};
			MIX_SPK:      chan_rd = {vol_spk, 6'd0};
			MIX_OUT_EN:   chan_rd = {3'd0, vol_en};
			MIX_REC_L:    chan_rd = {1'b0, rec_l};
			MIX_REC_R:    chan_rd = {1'b0, rec_r};
			default:      chan_rd = 8'h00;
		endcase
	end

	// readback follows the index, one cycle behind
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mixer_val <= '0;
		end else begin
			case (mix_index)
				MIX_VOICE:    mixer_val <= {vol_voice_l[4:1], vol_voice_r[4:1]} & vol_mask;
				MIX_STEREO:   mixer_val <= {6'd0, sbp_stereo, 1'b0};
				MIX_MASTER:   mixer_val <= {vol_master_l[4:1], vol_master_r[4:1]} & vol_mask;
				MIX_MIDI:     mixer_val <= {vol_midi_l[4:1], vol_midi_r[4:1]} & vol_mask;
				MIX_CD:       mixer_val <= {vol_cd_l[4:1], vol_cd_r[4:1]} & vol_mask;
				MIX_LINE:     mixer_val <= {vol_line_l[4:1], vol_line_r[4:1]} & vol_mask;
				MIX_IRQ_SEL:  mixer_val <= {4'h0, irq_10_en, irq_7_en, irq_5_en, 1'b0};
				MIX_DMA_SEL:  mixer_val <= {2'b00, dma_16_en, 1'b0, 4'h2};  // dma 5 / 1
				MIX_IRQ_STAT: mixer_val <= {6'd0, irq16, irq8};
				default:      mixer_val <= sbp ? 8'h00 : chan_rd;
			endcase
		end
	end

	a_one_irq: assert property (@(posedge clk) disable iff (!rst_n) !(irq_7_en && irq_10_en));

endmodule

`default_nettype wire

// File: hw/sb_dsp.sv
`default_nettype none

module sb_dsp (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             ce_1us,
	input  sb_pkg::io_addr_t io_address,
	input  logic             io_read,
	input  logic             io_write,
	input  sb_pkg::byte_t    io_writedata,
	output sb_pkg::byte_t    dsp_readdata,
	output logic             irq8,
	output logic             irq16,
	output sb_pkg::byte_t    dac_value,
	output logic             dac_valid
);
	import sb_pkg::*;

	localparam int CNT_W = $clog2(DSP_RESET_US + 1);

	dsp_state_t       state;
	logic [CNT_W-1:0] us_cnt;
	byte_t            out_data;     // output latch at offset A
	logic             data_ready;
	logic             minor_pend;   // second version byte queued
	logic             reset_wr;
	logic             cmd_wr;
	logic             data_rd;
	logic             stat_rd;
	logic             dac_wr;

	assign reset_wr = io_write && io_address == PORT_DSP_RESET;
	assign cmd_wr   = io_write && io_address == PORT_DSP_WRITE;
	assign data_rd  = io_read && io_address == PORT_DSP_READ;
	assign stat_rd  = io_read && io_address == PORT_DSP_STATUS;
	assign dac_wr   = cmd_wr && state == DAC_ARG;

	assign irq16 = 1'b0;  // no 16-bit transfers here

	always_comb begin
		case (io_address)
			PORT_DSP_READ:   dsp_readdata = out_data;
			PORT_DSP_WRITE:  dsp_readdata = 8'h7F;  // never busy
			PORT_DSP_STATUS: dsp_readdata = {data_ready, 7'h7F};
			default:         dsp_readdata = 8'hFF;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= IDLE;
			us_cnt     <= '0;
			out_data   <= '0;
			data_ready <= 1'b0;
			minor_pend <= 1'b0;
			irq8       <= 1'b0;
		end else begin
			if (data_rd) begin
				if (minor_pend)
					out_data <= DSP_VER_MINOR;
				data_ready <= minor_pend;
				minor_pend <= 1'b0;
			end
			if (stat_rd)
				irq8 <= 1'b0;  // status read acks the 8-bit irq

			if (reset_wr && io_writedata[0]) begin
				state      <= RESET_HOLD;
				data_ready <= 1'b0;
				minor_pend <= 1'b0;
				irq8       <= 1'b0;
			end else begin
				case (state)
					IDLE: ;   // waits for the first reset handshake
					RESET_HOLD: begin
						if (reset_wr) begin  // falling edge of the reset bit
							state  <= RESET_WAIT;
							us_cnt <= '0;
						end
					end
					RESET_WAIT: begin
						if (ce_1us) begin
							if (us_cnt == CNT_W'(DSP_RESET_US - 1)) begin
								out_data   <= DSP_RESET_ACK;
								data_ready <= 1'b1;
								state      <= CMD;
							end else begin
								us_cnt <= us_cnt + 1'b1;
							end
						end
					end
					CMD: begin
						if (cmd_wr) begin
							case (io_writedata)
								DSP_CMD_DAC: state <= DAC_ARG;
								DSP_CMD_VERSION: begin
									out_data   <= DSP_VER_MAJOR;
									data_ready <= 1'b1;
									minor_pend <= 1'b1;
								end
								DSP_CMD_IRQ8: irq8 <= 1'b1;
								default: ;  // unsupported commands are dropped
							endcase
						end
					end
					DAC_ARG: begin
						if (cmd_wr)
							state <= CMD;
					end
					default: state <= IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			dac_valid <= 1'b0;
		else
			dac_valid <= dac_wr;
	end

	always_ff @(posedge clk)
		if (dac_wr)
			dac_value <= io_writedata;

	// the argument byte sends the FSM back to command decode
	a_dac_valid: assert property (@(posedge clk) disable iff (!rst_n)
		dac_valid |-> $past(state) == DAC_ARG && state == CMD);

endmodule

`default_nettype wire

// File: hw/sb_sample_scale.sv
`default_nettype none

module sb_sample_scale (
	input  logic            clk,
	input  logic            rst_n,
	input  sb_pkg::byte_t   dac_value,
	input  logic            dac_valid,
	input  sb_pkg::vol_t    vol_l,
	input  sb_pkg::vol_t    vol_r,
	output sb_pkg::sample_t sample_l,
	output sb_pkg::sample_t sample_r
);
	import sb_pkg::*;

	sample_t dac_sample;

	// zero volume mutes, otherwise 6 dB per step of vol[4:1]
	function automatic sample_t scale(input sample_t s, input vol_t v);
		logic [3:0] shift;
		shift = ~v[4:1];
		if (v == '0)
			return '0;
		return s >>> shift;
	endfunction

	// offset binary to two's complement, moved into the top byte
	assign dac_sample = {dac_value - 8'd128, 8'h00};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sample_l <= '0;
			sample_r <= '0;
		end else if (dac_valid) begin
			sample_l <= scale(dac_sample, vol_l);
			sample_r <= scale(dac_sample, vol_r);
		end
	end

endmodule

`default_nettype wire

// File: hw/sb_io.sv
`default_nettype none

module sb_io (
	input  logic             clk,
	input  logic             rst_n,
	input  sb_pkg::rate_t    clock_rate,
	input  sb_pkg::io_addr_t address,
	input  logic             read,
	input  logic             write,
	input  logic             sb_cs,      // 220h-22Fh
	input  sb_pkg::byte_t    writedata,
	output sb_pkg::byte_t    readdata,
	output logic             irq_5,
	output logic             irq_7,
	output logic             irq_10,
	output sb_pkg::vol_t     vol_l,
	output sb_pkg::vol_t     vol_r,
	output sb_pkg::vol_t     vol_cd_l,
	output sb_pkg::vol_t     vol_cd_r,
	output sb_pkg::vol_t     vol_midi_l,
	output sb_pkg::vol_t     vol_midi_r,
	output sb_pkg::vol_t     vol_line_l,
	output sb_pkg::vol_t     vol_line_r,
	output logic [1:0]       vol_spk,
	output logic [4:0]       vol_en,
	output logic             dma_16_en,
	output sb_pkg::sample_t  sample_l,
	output sb_pkg::sample_t  sample_r
);
	import sb_pkg::*;

	logic  sb_read;
	logic  sb_write;
	logic  ce_1us;
	byte_t dsp_readdata;
	byte_t mixer_val;
	logic  irq8;
	logic  irq16;
	logic  irq;
	logic  irq_7_en;
	logic  irq_10_en;
	byte_t dac_value;
	logic  dac_valid;
	vol_t  vol_voice_l;
	vol_t  vol_voice_r;

	assign sb_read  = read & sb_cs;
	assign sb_write = write & sb_cs;

	// mixer data port or DSP, sampled every cycle
	always_ff @(posedge clk) begin
		if (!rst_n)
			readdata <= '0;
		else
			readdata <= (address == PORT_MIX_DATA) ? mixer_val : dsp_readdata;
	end

	assign irq    = irq8 | irq16;
	assign irq_5  = irq & ~irq_7_en & ~irq_10_en;  // default line
	assign irq_7  = irq & irq_7_en;
	assign irq_10 = irq & irq_10_en;

	sb_ce_gen u_ce_gen (
		.clk        (clk),
		.rst_n      (rst_n),
		.clock_rate (clock_rate),
		.ce         (ce_1us)
	);

	sb_dsp u_dsp (
		.clk          (clk),
		.rst_n        (rst_n),
		.ce_1us       (ce_1us),
		.io_address   (address),
		.io_read      (sb_read),
		.io_write     (sb_write),
		.io_writedata (writedata),
		.dsp_readdata (dsp_readdata),
		.irq8         (irq8),
		.irq16        (irq16),
		.dac_value    (dac_value),
		.dac_valid    (dac_valid)
	);

	sb_mixer_regs u_mixer (
		.clk          (clk),
		.rst_n        (rst_n),
		.io_address   (address),
		.io_write     (sb_write),
		.io_writedata (writedata),
		.irq8         (irq8),
		.irq16        (irq16),
		.mixer_val    (mixer_val),
		.vol_master_l (vol_l),
		.vol_master_r (vol_r),
		.vol_voice_l  (vol_voice_l),
		.vol_voice_r  (vol_voice_r),
		.vol_midi_l   (vol_midi_l),
		.vol_midi_r   (vol_midi_r),
		.vol_cd_l     (vol_cd_l),
		.vol_cd_r     (vol_cd_r),
		.vol_line_l   (vol_line_l),
		.vol_line_r   (vol_line_r),
		.vol_spk      (vol_spk),
		.vol_en       (vol_en),
		.irq_7_en     (irq_7_en),
		.irq_10_en    (irq_10_en),
		.dma_16_en    (dma_16_en),
		.sbp_stereo   ()            // no stereo DMA playback here
	);

	sb_sample_scale u_scale (
		.clk       (clk),
		.rst_n     (rst_n),
		.dac_value (dac_value),
		.dac_valid (dac_valid),
		.vol_l     (vol_voice_l),
		.vol_r     (vol_voice_r),
		.sample_l  (sample_l),
		.sample_r  (sample_r)
	);

endmodule

`default_nettype wire

// File: verif/sb_tb.sv
`default_nettype none

module sb_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import sb_pkg::*;

	localparam int unsigned SEED = 32'h09a4e737;
	// reset handshake is about 500 cycles, the register tests a few hundred more
	localparam int TIMEOUT_CYCLES = 4000;

	logic     clk;
	logic     rst_n;
	rate_t    clock_rate;
	io_addr_t address;
	logic     read;
	logic     write;
	logic     sb_cs;
	byte_t    writedata;
	byte_t    readdata;
	logic     irq_5;
	logic     irq_7;
	logic     irq_10;
	vol_t     vol_l;
	vol_t     vol_r;
	vol_t     vol_cd_l;
	vol_t     vol_cd_r;
	vol_t     vol_midi_l;
	vol_t     vol_midi_r;
	vol_t     vol_line_l;
	vol_t     vol_line_r;
	logic [1:0] vol_spk;
	logic [4:0] vol_en;
	logic     dma_16_en;
	sample_t  sample_l;
	sample_t  sample_r;
	int       cycles = 0;

	sb_io sb_io_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.clock_rate (clock_rate),
		.address    (address),
		.read       (read),
		.write      (write),
		.sb_cs      (sb_cs),
		.writedata  (writedata),
		.readdata   (readdata),
		.irq_5      (irq_5),
		.irq_7      (irq_7),
		.irq_10     (irq_10),
		.vol_l      (vol_l),
		.vol_r      (vol_r),
		.vol_cd_l   (vol_cd_l),
		.vol_cd_r   (vol_cd_r),
		.vol_midi_l (vol_midi_l),
		.vol_midi_r (vol_midi_r),
		.vol_line_l (vol_line_l),
		.vol_line_r (vol_line_r),
		.vol_spk    (vol_spk),
		.vol_en     (vol_en),
		.dma_16_en  (dma_16_en),
		.sample_l   (sample_l),
		.sample_r   (sample_r)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped on error");
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES)
			abort_run($sformatf("timeout after %0d cycles, the DUT stopped responding", cycles));
	end

	// at most one interrupt line
	a_irq_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0({irq_5, irq_7, irq_10}))
		else abort_run("more than one irq line high at once");

	// volumes only move on a host write
	a_vol_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!$past(write && sb_cs) |-> $stable(vol_l) && $stable(vol_r))
		else abort_run("master volume changed without a host write");

	a_sample_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		!$past(write && sb_cs, 2) |-> $stable(sample_l) && $stable(sample_r))
		else abort_run("sample changed without a DAC write");

	task automatic expect_eq(input string name, input int got, input int exp);
		assert (got == exp)
			else abort_run($sformatf("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp));
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic bus_write(input io_addr_t addr, input byte_t data);
		address   = addr;
		writedata = data;
		write     = 1'b1;
		sb_cs     = 1'b1;
		@(posedge clk);
		#2;
		write = 1'b0;
		sb_cs = 1'b0;
	endtask

	task automatic bus_read(input io_addr_t addr, output byte_t data);
		address = addr;
		read    = 1'b1;
		sb_cs   = 1'b1;
		@(posedge clk);
		#2;
		read  = 1'b0;
		sb_cs = 1'b0;
		data  = readdata;  // registered on the edge that closed the read
	endtask

	task automatic mixer_write(input byte_t idx, input byte_t data);
		bus_write(PORT_MIX_INDEX, idx);
		bus_write(PORT_MIX_DATA, data);
	endtask

	task automatic check_mixer(input byte_t idx, input byte_t exp);
		byte_t d;
		bus_write(PORT_MIX_INDEX, idx);
		idle(1);  // mixer_val catches up with the new index
		bus_read(PORT_MIX_DATA, d);
		expect_eq($sformatf("mixer[%02h]", idx), d, exp);
	endtask

	task automatic check_vol_defaults();
		expect_eq("vol_l", vol_l, 31);
		expect_eq("vol_r", vol_r, 31);
		expect_eq("vol_cd_l", vol_cd_l, 31);
		expect_eq("vol_cd_r", vol_cd_r, 31);
		expect_eq("vol_midi_l", vol_midi_l, 31);
		expect_eq("vol_midi_r", vol_midi_r, 31);
		expect_eq("vol_line_l", vol_line_l, 31);
		expect_eq("vol_line_r", vol_line_r, 31);
		expect_eq("vol_spk", vol_spk, 3);
		expect_eq("vol_en", vol_en, 5'h1F);
	endtask

	// port behind an SB16 channel register, -1 for voice (no port)
	function automatic int vol_port(input int idx);
		case (idx)
			'h30: return vol_l;
			'h31: return vol_r;
			'h34: return vol_midi_l;
			'h35: return vol_midi_r;
			'h36: return vol_cd_l;
			'h37: return vol_cd_r;
			'h38: return vol_line_l;
			'h39: return vol_line_r;
			default: return -1;
		endcase
	endfunction

	function automatic vol_t sb16_field(input logic [2:0] f);
		return {f, f[2:1]};
	endfunction

	function automatic vol_t sbp_field(input logic [3:0] n);
		return {n, n[3]};
	endfunction

	// unsigned byte around 128, top byte of 16 bits, 6 dB per volume step
	function automatic int expected_sample(input byte_t dac, input vol_t v);
		int s;
		s = (int'(dac) - 128) * 256;
		if (v == 0)
			return 0;
		return s >>> (15 - int'(v[4:1]));
	endfunction

	initial begin
		byte_t d;
		byte_t val;
		byte_t sel;
		byte_t dac;
		vol_t  lv;
		vol_t  rv;
		int    i;
		int    polls;
		int    seed_dummy;
		int    exp_l;
		int    exp_r;

		seed_dummy = $urandom(SEED);
		clock_rate = 28'd25_000_000;
		address    = '0;
		read       = 1'b0;
		write      = 1'b0;
		sb_cs      = 1'b0;
		writedata  = '0;
		rst_n      = 1'b0;
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;

		check_vol_defaults();
		expect_eq("irq lines", {irq_10, irq_7, irq_5}, 0);
		check_mixer(MIX_MASTER, 8'hFF);
		check_mixer(MIX_IRQ_SEL, 8'h02);
		check_mixer(MIX_DMA_SEL, 8'h22);
		expect_eq("dma_16_en", dma_16_en, 1);
		mixer_write(MIX_DMA_SEL, 8'h02);  // 16-bit channel off
		check_mixer(MIX_DMA_SEL, 8'h02);
		expect_eq("dma_16_en", dma_16_en, 0);
		mixer_write(MIX_DMA_SEL, 8'h22);
		expect_eq("dma_16_en", dma_16_en, 1);

		// SB16 per-channel map
		for (i = 'h30; i <= 'h39; i++) begin
			val = byte_t'($urandom);
			mixer_write(byte_t'(i), val);
			check_mixer(byte_t'(i), val & 8'hF8);
			if (vol_port(i) >= 0)
				expect_eq($sformatf("vol port %02h", i), vol_port(i), val[7:3]);
		end
		val = byte_t'($urandom);
		mixer_write(MIX_SPK, val);
		check_mixer(MIX_SPK, {val[7:6], 6'd0});
		expect_eq("vol_spk", vol_spk, val[7:6]);
		val = byte_t'($urandom);
		mixer_write(MIX_OUT_EN, val);
		check_mixer(MIX_OUT_EN, {3'd0, val[4:0]});
		expect_eq("vol_en", vol_en, val[4:0]);
		mixer_write(MIX_RESET, 8'h00);
		check_vol_defaults();
		check_mixer(MIX_MASTER_L, 8'hF8);

		// SB Pro map
		mixer_write(MIX_IRQ_SEL, 8'hAD);
		val = byte_t'($urandom);
		mixer_write(MIX_MASTER, val);
		check_mixer(MIX_MASTER, val & 8'hEE);
		expect_eq("vol_l", vol_l, sbp_field(val[7:4]));
		expect_eq("vol_r", vol_r, sbp_field(val[3:0]));
		mixer_write(MIX_MASTER_L, ~val);  // read only here
		expect_eq("vol_l", vol_l, sbp_field(val[7:4]));
		check_mixer(MIX_MASTER_L, 8'h00);
		mixer_write(MIX_IRQ_SEL, 8'hAE);
		val = byte_t'($urandom);
		mixer_write(MIX_MASTER, val);
		lv = sb16_field(val[7:5]);
		rv = sb16_field(val[3:1]);
		check_mixer(MIX_MASTER, {lv[4:1], rv[4:1]});
		expect_eq("vol_l", vol_l, lv);
		expect_eq("vol_r", vol_r, rv);
		check_mixer(MIX_MASTER_L, {lv, 3'd0});
		check_mixer(MIX_IRQ_SEL, 8'h02);

		// DSP reset, 20 us at 25 cycles per us give or take one tick
		bus_write(PORT_DSP_RESET, 8'h01);
		bus_write(PORT_DSP_RESET, 8'h00);
		d     = '0;
		polls = 0;
		while (!d[7]) begin
			bus_read(PORT_DSP_STATUS, d);
			polls++;
		end
		assert (polls >= 475 && polls <= 525)
			else abort_run($sformatf("DSP reset handshake took %0d cycles", polls));
		bus_read(PORT_DSP_READ, d);
		expect_eq("dsp reset ack", d, 8'hAA);
		bus_read(PORT_DSP_STATUS, d);
		expect_eq("dsp data ready", d[7], 0);
		bus_write(PORT_DSP_WRITE, DSP_CMD_VERSION);
		bus_read(PORT_DSP_READ, d);
		expect_eq("dsp version major", d, 8'h04);
		bus_read(PORT_DSP_READ, d);
		expect_eq("dsp version minor", d, 8'h05);

		// bit 1 is IRQ 5, bit 2 IRQ 7, bit 3 IRQ 10
		for (i = 0; i < 3; i++) begin
			case (i)
				0: sel = 8'h04;
				1: sel = 8'h08;
				default: sel = 8'h02;
			endcase
			mixer_write(MIX_IRQ_SEL, sel);
			check_mixer(MIX_IRQ_SEL, sel);
			expect_eq("irq lines idle", {irq_10, irq_7, irq_5}, 0);
			bus_write(PORT_DSP_WRITE, DSP_CMD_IRQ8);
			expect_eq("irq lines", {irq_10, irq_7, irq_5}, sel[3:1]);
			check_mixer(MIX_IRQ_STAT, 8'h01);
			bus_read(PORT_DSP_STATUS, d);
			expect_eq("irq lines after ack", {irq_10, irq_7, irq_5}, 0);
		end

		// direct DAC through the voice volume
		exp_l = 0;
		exp_r = 0;
		for (i = 0; i < 10; i++) begin
			lv  = vol_t'($urandom);
			rv  = vol_t'($urandom);
			dac = byte_t'($urandom);
			if (i == 0)
				lv = 0;
			if (i == 1)
				rv = 0;
			if (i == 2)
				lv = 31;
			mixer_write(MIX_VOICE_L, {lv, 3'd0});
			mixer_write(MIX_VOICE_R, {rv, 3'd0});
			bus_write(PORT_DSP_WRITE, DSP_CMD_DAC);
			bus_write(PORT_DSP_WRITE, dac);
			expect_eq("sample_l early", sample_l, exp_l);  // still the old one
			expect_eq("sample_r early", sample_r, exp_r);
			exp_l = expected_sample(dac, lv);
			exp_r = expected_sample(dac, rv);
			idle(1);
			expect_eq("sample_l", sample_l, exp_l);
			expect_eq("sample_r", sample_r, exp_r);
		end

		idle(2);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
hw/sb_pkg.sv
hw/sb_ce_gen.sv
hw/sb_mixer_regs.sv
hw/sb_dsp.sv
hw/sb_sample_scale.sv
hw/sb_io.sv
verif/sb_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the sb_io testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f src.f --top-module sb_tb -o sb_tb_sim

# tee keeps the pipeline status at zero, the log decides the result
./obj_dir/sb_tb_sim 2>&1 | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi

echo "simulation passed"
exit 0
